// ==== axi_write_top.f ====
src/axi_pkg.sv
src/lsu_pkg.sv
src/axi_write_id_table.sv
src/axi_write_aw_gen.sv
src/axi_write_w_chan.sv
src/axi_write_b_chan.sv
src/axi_write_top.sv
testbench/tb_axi_write_top.sv

// ==== testbench/tb_axi_write_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_axi_write_top;

    localparam int NUM_REQ        = 40;
    localparam int TIMEOUT_CYCLES = NUM_REQ * 4 * 5 * 8 + 200;
    localparam int NUM_TESTS      = 5;
    localparam int T_RESET        = 0;
    localparam int T_AW           = 1;
    localparam int T_ID           = 2;
    localparam int T_W            = 3;
    localparam int T_RESP         = 4;

    logic                  clk = 1'b0;
    logic                  rst_n;
    lsu_pkg::lsu_wr_req_t  lsu_req;
    logic                  req_valid;
    logic                  req_ready;
    lsu_pkg::lsu_wr_beat_t lsu_beat;
    logic                  beat_valid;
    logic                  beat_ready;
    lsu_pkg::lsu_wr_resp_t lsu_resp;
    logic                  resp_valid;
    logic                  resp_ready;
    axi_pkg::aw_chan_t     aw;
    logic                  awvalid;
    logic                  awready;
    axi_pkg::w_chan_t      w;
    logic                  wvalid;
    logic                  wready;
    axi_pkg::b_chan_t      b;
    logic                  bvalid;
    logic                  bready;

    logic [31:0] lfsr_state = 32'hf3e9f384;
    int          cycle_cnt  = 0;
    int          checks [NUM_TESTS];
    int          errors [NUM_TESTS];
    string       test_name [NUM_TESTS];

    // reference model state
    axi_pkg::aw_chan_t                   exp_aw [$];
    logic [lsu_pkg::ORAM_ADDR_WIDTH-1:0] exp_oram [$];
    axi_pkg::w_chan_t                    exp_w [$];
    logic [axi_pkg::ID_WIDTH-1:0]        model_id;
    logic [axi_pkg::LEN_WIDTH-1:0]       cur_len;
    logic [axi_pkg::LEN_WIDTH-1:0]       beat_idx;
    logic [lsu_pkg::SLOTS-1:0]           busy;
    logic [lsu_pkg::ORAM_ADDR_WIDTH-1:0] oram_model [lsu_pkg::SLOTS];
    int                                  total_bursts;
    int                                  resp_cnt;

    // slave model state
    logic [axi_pkg::ID_WIDTH-1:0] aw_ids [int];
    int                           aw_cnt;
    int                           wlast_cnt;
    int                           matched;
    logic [axi_pkg::ID_WIDTH-1:0] pending_ids [$];
    logic [axi_pkg::ID_WIDTH-1:0] b_fifo_id [$];
    axi_pkg::axi_resp_e           b_fifo_resp [$];
    bit                           b_taken;

    axi_write_top i_axi_write_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .lsu_req    (lsu_req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .lsu_beat   (lsu_beat),
        .beat_valid (beat_valid),
        .beat_ready (beat_ready),
        .lsu_resp   (lsu_resp),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .aw         (aw),
        .awvalid    (awvalid),
        .awready    (awready),
        .w          (w),
        .wvalid     (wvalid),
        .wready     (wready),
        .b          (b),
        .bvalid     (bvalid),
        .bready     (bready)
    );

    always #50 clk = ~clk;

    // galois lfsr, one step per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] val;
        logic        bit_out;
        val = '0;
        for (int i = 0; i < n; i++) begin
            bit_out    = lfsr_state[0];
            lfsr_state = (lfsr_state >> 1) ^ (bit_out ? 32'h80200003 : 32'h0);
            val        = {val[62:0], bit_out};
        end
        return val;
    endfunction

    function automatic lsu_pkg::lsu_wr_req_t make_request();
        lsu_pkg::lsu_wr_req_t r;
        r.addr      = 10'(rand_bits(10));
        r.len       = 8'(rand_bits(2));
        r.size      = 3'(rand_bits(3));
        r.burst     = axi_pkg::axi_burst_e'(2'(rand_bits(2) % 3));
        r.stride    = lsu_pkg::lsu_stride_e'(3'(rand_bits(3) % 5));
        r.num       = 4'(rand_bits(2));
        r.oram_addr = 12'(rand_bits(12));
        return r;
    endfunction

    task automatic report_error(input int t, input string msg);
        errors[t]++;
        $display("%s: %s", test_name[t], msg);
    endtask

    task automatic check_flags(input int t, input logic [4:0] exp, input logic [4:0] act);
        checks[t]++;
        if (exp !== act) begin
            errors[t]++;
            $display("FAIL %s: expected %b actual %b", test_name[t], exp, act);
        end
    endtask

    task automatic check_aw(input int t, input axi_pkg::aw_chan_t exp,
                            input axi_pkg::aw_chan_t act);
        checks[t]++;
        if (exp !== act) begin
            errors[t]++;
            $display("FAIL %s: expected %h actual %h", test_name[t], exp, act);
        end
    endtask

    task automatic check_w(input int t, input axi_pkg::w_chan_t exp,
                           input axi_pkg::w_chan_t act);
        checks[t]++;
        if (exp !== act) begin
            errors[t]++;
            $display("FAIL %s: expected %h actual %h", test_name[t], exp, act);
        end
    endtask

    task automatic check_resp(input int t, input lsu_pkg::lsu_wr_resp_t exp,
                              input lsu_pkg::lsu_wr_resp_t act);
        checks[t]++;
        if (exp !== act) begin
            errors[t]++;
            $display("FAIL %s: expected %h actual %h", test_name[t], exp, act);
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // axi slave, random ready and out of order B
    always @(negedge clk) begin
        int idx;
        awready    = rand_bits(2) != 0;
        wready     = rand_bits(2) != 0;
        // rare lsu acceptance so the id ring fills up
        resp_ready = rand_bits(3) == 0;
        if (b_taken) begin
            bvalid  = 1'b0;
            b_taken = 1'b0;
        end
        if (!bvalid && pending_ids.size() > 0 && rand_bits(1) == 1) begin
            idx    = int'(rand_bits(4)) % pending_ids.size();
            b.id   = pending_ids[idx];
            b.resp = axi_pkg::axi_resp_e'(2'(rand_bits(2)));
            pending_ids.delete(idx);
            bvalid = 1'b1;
        end
    end

    // monitor and reference model, all handshakes seen at the rising edge
    always @(posedge clk) begin
        axi_pkg::aw_chan_t                   ea;
        axi_pkg::w_chan_t                    ew;
        lsu_pkg::lsu_wr_resp_t               er;
        logic [lsu_pkg::ORAM_ADDR_WIDTH-1:0] eo;
        logic [axi_pkg::ID_WIDTH-1:0]        rid;
        int                                  step;
        if (rst_n) begin
            if (req_valid && req_ready) begin
                step    = 16 << int'(lsu_req.stride);
                cur_len = lsu_req.len;
                for (int k = 0; k <= int'(lsu_req.num); k++) begin
                    ea.id    = model_id;
                    ea.addr  = 10'(int'(lsu_req.addr) + k * step);
                    ea.len   = lsu_req.len;
                    ea.size  = lsu_req.size;
                    ea.burst = lsu_req.burst;
                    exp_aw.push_back(ea);
                    exp_oram.push_back(12'(int'(lsu_req.oram_addr) + k));
                    model_id     = model_id + 1'b1;
                    total_bursts = total_bursts + 1;
                end
            end
            if (awvalid && awready) begin
                if (exp_aw.size() == 0) begin
                    report_error(T_AW, "AW burst issued that no request asked for");
                end else begin
                    ea = exp_aw.pop_front();
                    eo = exp_oram.pop_front();
                    check_aw(T_AW, ea, aw);
                    checks[T_ID]++;
                    if (busy[aw.id]) begin
                        report_error(T_ID, $sformatf("AWID %0d reused before its response", aw.id));
                    end
                    busy[aw.id]       = 1'b1;
                    oram_model[aw.id] = eo;
                    aw_ids[aw_cnt]    = aw.id;
                    aw_cnt            = aw_cnt + 1;
                end
            end
            if (beat_valid && beat_ready) begin
                ew.data  = lsu_beat.data;
                ew.strb  = lsu_beat.strb;
                ew.last  = (beat_idx == cur_len);
                beat_idx = ew.last ? '0 : beat_idx + 1'b1;
                exp_w.push_back(ew);
            end
            if (wvalid && wready) begin
                if (exp_w.size() == 0) begin
                    report_error(T_W, "W beat sent that the LSU never handed over");
                end else begin
                    ew = exp_w.pop_front();
                    check_w(T_W, ew, w);
                    if (ew.last) begin
                        wlast_cnt = wlast_cnt + 1;
                    end
                end
            end
            // a burst completes once its AW and its last beat are both in
            while (matched < aw_cnt && matched < wlast_cnt) begin
                pending_ids.push_back(aw_ids[matched]);
                matched = matched + 1;
            end
            if (bvalid && bready) begin
                b_fifo_id.push_back(b.id);
                b_fifo_resp.push_back(b.resp);
                b_taken = 1'b1;
            end
            if (resp_valid && resp_ready) begin
                if (b_fifo_id.size() == 0) begin
                    report_error(T_RESP, "LSU response without a B response behind it");
                end else begin
                    rid          = b_fifo_id.pop_front();
                    er.resp      = b_fifo_resp.pop_front();
                    er.oram_addr = oram_model[rid];
                    check_resp(T_RESP, er, lsu_resp);
                    busy[rid] = 1'b0;
                    resp_cnt  = resp_cnt + 1;
                end
            end
        end
    end

    initial begin
        lsu_pkg::lsu_wr_req_t  r;
        lsu_pkg::lsu_wr_beat_t bt;
        int                    nbeats;
        int                    failed_tests;
        rst_n      = 1'b0;
        lsu_req    = '0;
        req_valid  = 1'b0;
        lsu_beat   = '0;
        beat_valid = 1'b0;
        resp_ready = 1'b0;
        awready    = 1'b0;
        wready     = 1'b0;
        b          = '0;
        bvalid     = 1'b0;
        b_taken    = 1'b0;
        model_id   = '0;
        cur_len    = '0;
        beat_idx   = '0;
        busy       = '0;
        total_bursts = 0;
        resp_cnt     = 0;
        aw_cnt       = 0;
        wlast_cnt    = 0;
        matched      = 0;
        test_name = '{"reset_values", "aw_bursts", "aw_id_reuse", "w_beats", "responses"};
        for (int t = 0; t < NUM_TESTS; t++) begin
            checks[t] = 0;
            errors[t] = 0;
        end
        r = make_request();

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_flags(T_RESET, 5'b00011, {awvalid, wvalid, resp_valid, req_ready, bready});
        $display("test %s: %0d checks, %0d errors", test_name[T_RESET],
                 checks[T_RESET], errors[T_RESET]);

        // one request, then all of its beats, so burst_len matches the beats
        for (int n = 0; n < NUM_REQ; n++) begin
            @(negedge clk);
            lsu_req   = r;
            req_valid = 1'b1;
            do @(posedge clk); while (!req_ready);
            nbeats = (int'(r.num) + 1) * (int'(r.len) + 1);
            for (int j = 0; j < nbeats; j++) begin
                bt.data = rand_bits(64);
                bt.strb = 8'(rand_bits(8));
                @(negedge clk);
                req_valid  = 1'b0;
                lsu_beat   = bt;
                beat_valid = 1'b1;
                do @(posedge clk); while (!beat_ready);
            end
            r = make_request();
            @(negedge clk);
            beat_valid = 1'b0;
        end

        while (resp_cnt < total_bursts) @(negedge clk);
        if (exp_aw.size() != 0) begin
            report_error(T_AW, $sformatf("%0d bursts never issued on AW", exp_aw.size()));
        end
        if (exp_w.size() != 0) begin
            report_error(T_W, $sformatf("%0d beats never left on W", exp_w.size()));
        end
        if (b_fifo_id.size() != 0 || pending_ids.size() != 0) begin
            report_error(T_RESP, "B responses left over at the end of the run");
        end

        failed_tests = 0;
        for (int t = 1; t < NUM_TESTS; t++) begin
            $display("test %s: %0d checks, %0d errors", test_name[t], checks[t], errors[t]);
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            if (errors[t] != 0) begin
                failed_tests++;
            end
        end
        $display("%0d tests, %0d passed, %0d failed, %0d bursts", NUM_TESTS,
                 NUM_TESTS - failed_tests, failed_tests, total_bursts);
        if (failed_tests == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/axi_write_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_write_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  lsu_pkg::lsu_wr_req_t  lsu_req,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  lsu_pkg::lsu_wr_beat_t lsu_beat,
    input  logic                  beat_valid,
    output logic                  beat_ready,
    output lsu_pkg::lsu_wr_resp_t lsu_resp,
    output logic                  resp_valid,
    input  logic                  resp_ready,
    output axi_pkg::aw_chan_t     aw,
    output logic                  awvalid,
    input  logic                  awready,
    output axi_pkg::w_chan_t      w,
    output logic                  wvalid,
    input  logic                  wready,
    input  axi_pkg::b_chan_t      b,
    input  logic                  bvalid,
    output logic                  bready
);

    logic                                alloc;
    logic [lsu_pkg::ORAM_ADDR_WIDTH-1:0] alloc_oram;
    logic                                slot_free;
    logic [axi_pkg::ID_WIDTH-1:0]        slot_id;
    logic [axi_pkg::LEN_WIDTH-1:0]       burst_len;
    logic [axi_pkg::ID_WIDTH-1:0]        lookup_id;
    logic [lsu_pkg::ORAM_ADDR_WIDTH-1:0] lookup_oram;
    logic                                release_en;
    logic [axi_pkg::ID_WIDTH-1:0]        release_id;

    axi_write_id_table i_id_table (
        .clk         (clk),
        .rst_n       (rst_n),
        .alloc       (alloc),
        .alloc_oram  (alloc_oram),
        .slot_free   (slot_free),
        .slot_id     (slot_id),
        .lookup_id   (lookup_id),
        .lookup_oram (lookup_oram),
        .release_en  (release_en),
        .release_id  (release_id)
    );

    axi_write_aw_gen i_aw_gen (
        .clk        (clk),
        .rst_n      (rst_n),
        .lsu_req    (lsu_req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .aw         (aw),
        .awvalid    (awvalid),
        .awready    (awready),
        .slot_free  (slot_free),
        .slot_id    (slot_id),
        .alloc      (alloc),
        .alloc_oram (alloc_oram),
        .burst_len  (burst_len)
    );

    axi_write_w_chan i_w_chan (
        .clk        (clk),
        .rst_n      (rst_n),
        .lsu_beat   (lsu_beat),
        .beat_valid (beat_valid),
        .beat_ready (beat_ready),
        .burst_len  (burst_len),
        .w          (w),
        .wvalid     (wvalid),
        .wready     (wready)
    );

    axi_write_b_chan i_b_chan (
        .clk         (clk),
        .rst_n       (rst_n),
        .b           (b),
        .bvalid      (bvalid),
        .bready      (bready),
        .lookup_id   (lookup_id),
        .lookup_oram (lookup_oram),
        .lsu_resp    (lsu_resp),
        .resp_valid  (resp_valid),
        .resp_ready  (resp_ready),
        .release_en  (release_en),
        .release_id  (release_id)
    );

endmodule

`default_nettype wire

// ==== src/axi_write_b_chan.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_write_b_chan (
    input  logic                                clk,
    input  logic                                rst_n,
    input  axi_pkg::b_chan_t                    b,
    input  logic                                bvalid,
    output logic                                bready,
    output logic [axi_pkg::ID_WIDTH-1:0]        lookup_id,
    input  logic [lsu_pkg::ORAM_ADDR_WIDTH-1:0] lookup_oram,
    output lsu_pkg::lsu_wr_resp_t               lsu_resp,
    output logic                                resp_valid,
    input  logic                                resp_ready,
    output logic                                release_en,
    output logic [axi_pkg::ID_WIDTH-1:0]        release_id
);

    logic                         resp_valid_q;
    logic                         b_hs;
    logic [axi_pkg::ID_WIDTH-1:0] bid_q;
    axi_pkg::axi_resp_e           bresp_q;

    assign bready = ~resp_valid_q;
    assign b_hs   = bvalid & bready;

    // oram address comes straight from the table slot
    assign lookup_id          = bid_q;
    assign lsu_resp.resp      = bresp_q;
    assign lsu_resp.oram_addr = lookup_oram;
    assign resp_valid         = resp_valid_q;

    // lsu acceptance frees the slot
    assign release_en = resp_valid_q & resp_ready;
    assign release_id = bid_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= b_hs | (resp_valid_q & ~resp_ready);
        end
    end

    always_ff @(posedge clk) begin
        if (b_hs) begin
            bid_q   <= b.id;
            bresp_q <= b.resp;
        end
    end

endmodule

`default_nettype wire

// ==== src/axi_write_w_chan.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_write_w_chan (
    input  logic                          clk,
    input  logic                          rst_n,
    input  lsu_pkg::lsu_wr_beat_t         lsu_beat,
    input  logic                          beat_valid,
    output logic                          beat_ready,
    input  logic [axi_pkg::LEN_WIDTH-1:0] burst_len,
    output axi_pkg::w_chan_t              w,
    output logic                          wvalid,
    input  logic                          wready
);

    axi_pkg::w_chan_t              w_q;
    logic                          wvalid_q;
    logic                          beat_hs;
    logic                          beat_last;
    logic [axi_pkg::LEN_WIDTH-1:0] beat_cnt;

    // single entry, refill only once empty
    assign beat_ready = ~wvalid_q;
    assign beat_hs    = beat_valid & beat_ready;
    assign beat_last  = (beat_cnt == burst_len);

    assign w      = w_q;
    assign wvalid = wvalid_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wvalid_q <= 1'b0;
            beat_cnt <= '0;
        end else begin
            wvalid_q <= beat_hs | (wvalid_q & ~wready);
            if (beat_hs) begin
                beat_cnt <= beat_last ? '0 : beat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (beat_hs) begin
            w_q.data <= lsu_beat.data;
            w_q.strb <= lsu_beat.strb;
            w_q.last <= beat_last;
        end
    end

    a_w_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(w)
    );

endmodule

`default_nettype wire

// ==== src/axi_write_aw_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_write_aw_gen (
    input  logic                                clk,
    input  logic                                rst_n,
    input  lsu_pkg::lsu_wr_req_t                lsu_req,
    input  logic                                req_valid,
    output logic                                req_ready,
    output axi_pkg::aw_chan_t                   aw,
    output logic                                awvalid,
    input  logic                                awready,
    input  logic                                slot_free,
    input  logic [axi_pkg::ID_WIDTH-1:0]        slot_id,
    output logic                                alloc,
    output logic [lsu_pkg::ORAM_ADDR_WIDTH-1:0] alloc_oram,
    output logic [axi_pkg::LEN_WIDTH-1:0]       burst_len
);

    typedef enum logic {
        IDLE  = 1'b0,
        ISSUE = 1'b1
    } aw_state_e;

    aw_state_e                           state;
    logic                                req_hs;
    logic [axi_pkg::ADDR_WIDTH-1:0]      addr_q;
    logic [axi_pkg::ADDR_WIDTH-1:0]      stride_bytes;
    logic [axi_pkg::LEN_WIDTH-1:0]       len_q;
    logic [axi_pkg::SIZE_WIDTH-1:0]      size_q;
    axi_pkg::axi_burst_e                 burst_q;
    lsu_pkg::lsu_stride_e                stride_q;
    logic [lsu_pkg::NUM_WIDTH-1:0]       num_q;
    logic [lsu_pkg::NUM_WIDTH-1:0]       cnt_q;
    logic [lsu_pkg::ORAM_ADDR_WIDTH-1:0] oram_q;

    assign req_ready = (state == IDLE);
    assign req_hs    = req_valid & req_ready;
    assign awvalid   = (state == ISSUE) & slot_free;
    assign alloc     = awvalid & awready;

    assign aw.id    = slot_id;
    assign aw.addr  = addr_q;
    assign aw.len   = len_q;
    assign aw.size  = size_q;
    assign aw.burst = burst_q;

    assign burst_len  = len_q;
    // oram block of burst k is base + k
    assign alloc_oram = oram_q
                      + {{(lsu_pkg::ORAM_ADDR_WIDTH - lsu_pkg::NUM_WIDTH){1'b0}}, cnt_q};

    always_comb begin
        case (stride_q)
            lsu_pkg::S16:  stride_bytes = 10'd16;
            lsu_pkg::S32:  stride_bytes = 10'd32;
            lsu_pkg::S64:  stride_bytes = 10'd64;
            lsu_pkg::S128: stride_bytes = 10'd128;
            lsu_pkg::S256: stride_bytes = 10'd256;
            default:       stride_bytes = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
            cnt_q <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (req_hs) begin
                        state <= ISSUE;
                        cnt_q <= '0;
                    end
                end
                ISSUE: begin
                    if (alloc) begin
                        cnt_q <= cnt_q + 1'b1;
                        if (cnt_q == num_q) begin
                            state <= IDLE;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_hs) begin
            addr_q   <= lsu_req.addr;
            len_q    <= lsu_req.len;
            size_q   <= lsu_req.size;
            burst_q  <= lsu_req.burst;
            stride_q <= lsu_req.stride;
            num_q    <= lsu_req.num;
            oram_q   <= lsu_req.oram_addr;
        end else if (alloc) begin
            addr_q <= addr_q + stride_bytes;
        end
    end

    a_aw_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid && $stable(aw)
    );

endmodule

`default_nettype wire

// ==== src/axi_write_id_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_write_id_table (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                alloc,
    input  logic [lsu_pkg::ORAM_ADDR_WIDTH-1:0] alloc_oram,
    output logic                                slot_free,
    output logic [axi_pkg::ID_WIDTH-1:0]        slot_id,
    input  logic [axi_pkg::ID_WIDTH-1:0]        lookup_id,
    output logic [lsu_pkg::ORAM_ADDR_WIDTH-1:0] lookup_oram,
    input  logic                                release_en,
    input  logic [axi_pkg::ID_WIDTH-1:0]        release_id
);

    logic [lsu_pkg::SLOTS-1:0]          slot_vld;
    logic [lsu_pkg::ORAM_ADDR_WIDTH-1:0] slot_oram [lsu_pkg::SLOTS];
    logic [axi_pkg::ID_WIDTH-1:0]       alloc_ptr;

    // ring allocation, a busy slot stalls the ring
    assign slot_id     = alloc_ptr;
    assign slot_free   = ~slot_vld[alloc_ptr];
    assign lookup_oram = slot_oram[lookup_id];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot_vld  <= '0;
            alloc_ptr <= '0;
        end else begin
            if (alloc) begin
                slot_vld[alloc_ptr] <= 1'b1;
                alloc_ptr           <= alloc_ptr + 1'b1;
            end
            // alloc needs a free slot and release a busy one, never the same
            if (release_en) begin
                slot_vld[release_id] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            slot_oram[alloc_ptr] <= alloc_oram;
        end
    end

    // aw side must wait for the ring slot to drain
    a_alloc_free: assert property (
        @(posedge clk) disable iff (!rst_n)
        alloc |-> slot_free
    );

    // responses only come back for bursts still in flight
    a_release_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        release_en |-> slot_vld[release_id] && slot_vld[lookup_id]
    );

endmodule

`default_nettype wire

// ==== src/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    localparam int unsigned ORAM_ADDR_WIDTH = 12;
    localparam int unsigned SLOTS           = 16;
    localparam int unsigned NUM_WIDTH       = 4;

    // byte distance between consecutive bursts
    typedef enum logic [2:0] {
        S16  = 3'd0,
        S32  = 3'd1,
        S64  = 3'd2,
        S128 = 3'd3,
        S256 = 3'd4
    } lsu_stride_e;

    // one write request, 42 bits
    typedef struct packed {
        logic [axi_pkg::ADDR_WIDTH-1:0] addr;
        logic [axi_pkg::LEN_WIDTH-1:0]  len;
        logic [axi_pkg::SIZE_WIDTH-1:0] size;
        axi_pkg::axi_burst_e            burst;
        lsu_stride_e                    stride;
        logic [NUM_WIDTH-1:0]           num;
        logic [ORAM_ADDR_WIDTH-1:0]     oram_addr;
    } lsu_wr_req_t;

    typedef struct packed {
        logic [axi_pkg::DATA_WIDTH-1:0] data;
        logic [axi_pkg::STRB_WIDTH-1:0] strb;
    } lsu_wr_beat_t;

    typedef struct packed {
        axi_pkg::axi_resp_e         resp;
        logic [ORAM_ADDR_WIDTH-1:0] oram_addr;
    } lsu_wr_resp_t;

endpackage

`default_nettype wire

// ==== src/axi_pkg.sv ====
`default_nettype none

package axi_pkg;

    localparam int unsigned ID_WIDTH   = 4;
    localparam int unsigned ADDR_WIDTH = 10;
    localparam int unsigned DATA_WIDTH = 64;
    localparam int unsigned STRB_WIDTH = DATA_WIDTH / 8;
    localparam int unsigned LEN_WIDTH  = 8;
    localparam int unsigned SIZE_WIDTH = 3;

    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } axi_burst_e;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    // write address channel, 27 bits
    typedef struct packed {
        logic [ID_WIDTH-1:0]   id;
        logic [ADDR_WIDTH-1:0] addr;
        logic [LEN_WIDTH-1:0]  len;
        logic [SIZE_WIDTH-1:0] size;
        axi_burst_e            burst;
    } aw_chan_t;

    // write data channel, 73 bits
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [STRB_WIDTH-1:0] strb;
        logic                  last;
    } w_chan_t;

    typedef struct packed {
        logic [ID_WIDTH-1:0] id;
        axi_resp_e           resp;
    } b_chan_t;

endpackage

`default_nettype wire
